//--- rtl/ddc_pkg.sv
package ddc_pkg;

	localparam int SAMPLE_W   = 16; // adc and i/q words
	localparam int PHASE_W    = 32; // accumulator and frequency word
	localparam int REG_ADDR_W = 7;

	localparam logic [REG_ADDR_W-1:0] ADDR_FREQ   = 7'h1;
	localparam logic [REG_ADDR_W-1:0] ADDR_OPTION = 7'h2;

	// option register low bits, 3 falls through to decimated
	typedef enum logic [1:0] {
		MODE_RAW   = 2'd0,
		MODE_MIXED = 2'd1,
		MODE_DECIM = 2'd2
	} capture_mode_t;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_Q,
		ST_I
	} writer_state_t;

	// atan(2^-i) with a full turn = 65536
	localparam logic [15:0] CORDIC_ATAN [16] = '{
		16'd8192, 16'd4836, 16'd2555, 16'd1297,
		16'd651,  16'd326,  16'd163,  16'd81,
		16'd41,   16'd20,   16'd10,   16'd5,
		16'd3,    16'd1,    16'd1,    16'd0
	};

endpackage

//--- rtl/ddc_regs.sv
module ddc_regs (
	input  logic                             i_rst,
	input  logic                             ENC_CLK,
	input  logic                             i_reg_wr,
	input  logic [ddc_pkg::REG_ADDR_W-1:0]   i_reg_addr,
	input  logic [ddc_pkg::PHASE_W-1:0]      i_reg_data,
	output logic [ddc_pkg::PHASE_W-1:0]      o_freq_word,
	output ddc_pkg::capture_mode_t           o_mode
);
	import ddc_pkg::*;

	always_ff @(posedge ENC_CLK) begin
		if (i_rst) begin
			o_freq_word <= '0;
			o_mode      <= MODE_RAW;
		end else if (i_reg_wr) begin
			case (i_reg_addr)
				ADDR_FREQ: begin
					o_freq_word <= i_reg_data;
				end
				ADDR_OPTION: begin
					o_mode <= capture_mode_t'(i_reg_data[1:0]); // only the mode bits kept
				end
				default: begin
					// unknown address, nothing to update
				end
			endcase
		end
	end

endmodule

//--- rtl/nco_mixer.sv
module nco_mixer #(
	parameter int CORDIC_STAGES = 14
) (
	input  logic                                ENC_CLK,
	input  logic                                i_rst,
	input  logic        [ddc_pkg::PHASE_W-1:0]  i_freq_word,
	input  logic signed [ddc_pkg::SAMPLE_W-1:0] i_sample,
	output logic signed [ddc_pkg::SAMPLE_W-1:0] o_i,
	output logic signed [ddc_pkg::SAMPLE_W-1:0] o_q
);
	import ddc_pkg::*;

	localparam int XW = SAMPLE_W + 2; // two guard bits below the lsb
	localparam int ZW = 16;           // angle resolution

	logic        [PHASE_W-1:0] phase_acc;
	logic        [ZW-1:0]      z_in;
	logic signed [XW-1:0]      x_in;
	logic signed [XW-1:0]      x0;
	logic        [ZW-1:0]      z0;

	logic signed [XW-1:0] x_r [0:CORDIC_STAGES];
	logic signed [XW-1:0] y_r [0:CORDIC_STAGES];
	logic signed [ZW-1:0] z_r [0:CORDIC_STAGES];

	always_ff @(posedge ENC_CLK) begin
		if (i_rst)
			phase_acc <= '0;
		else
			phase_acc <= phase_acc + i_freq_word;
	end

	assign z_in = phase_acc[PHASE_W-1 -: ZW];

	// halve the sample, which with the guard bits is sample*2
	assign x_in = {i_sample[SAMPLE_W-1], i_sample, 1'b0};

	// fold quadrants 1 and 2 by 180 degrees into +-90
	always_comb begin
		if (z_in[ZW-1] ^ z_in[ZW-2]) begin
			x0 = -x_in;
			z0 = {~z_in[ZW-1], z_in[ZW-2:0]};
		end else begin
			x0 = x_in;
			z0 = z_in;
		end
	end

	// rotation mode, drive the residual angle to zero
	always_ff @(posedge ENC_CLK) begin
		x_r[0] <= x0;
		y_r[0] <= '0; // q input is always zero
		z_r[0] <= z0;
		for (int s = 0; s < CORDIC_STAGES; s++) begin
			if (z_r[s][ZW-1]) begin // angle negative, turn clockwise
				x_r[s+1] <= x_r[s] + (y_r[s] >>> s);
				y_r[s+1] <= y_r[s] - (x_r[s] >>> s);
				z_r[s+1] <= z_r[s] + $signed(CORDIC_ATAN[s]);
			end else begin
				x_r[s+1] <= x_r[s] - (y_r[s] >>> s);
				y_r[s+1] <= y_r[s] + (x_r[s] >>> s);
				z_r[s+1] <= z_r[s] - $signed(CORDIC_ATAN[s]);
			end
		end
	end

	// drop the guard bits, gain of ~1.647 stays in
	assign o_i = x_r[CORDIC_STAGES][XW-1:2];
	assign o_q = y_r[CORDIC_STAGES][XW-1:2];

endmodule

//--- rtl/decimator.sv
module decimator #(
	parameter int DECIM = 8
) (
	input  logic                                ENC_CLK,
	input  logic                                i_rst,
	input  logic signed [ddc_pkg::SAMPLE_W-1:0] i_in_i,
	input  logic signed [ddc_pkg::SAMPLE_W-1:0] i_in_q,
	output logic signed [ddc_pkg::SAMPLE_W-1:0] o_out_i,
	output logic signed [ddc_pkg::SAMPLE_W-1:0] o_out_q,
	output logic                                o_valid
);
	import ddc_pkg::*;

	localparam int SHIFT = $clog2(DECIM); // DECIM is at least 2
	localparam int AW    = SAMPLE_W + SHIFT;

	logic        [SHIFT-1:0] cnt;
	logic signed [AW-1:0]    acc_i;
	logic signed [AW-1:0]    acc_q;
	logic signed [AW-1:0]    sum_i;
	logic signed [AW-1:0]    sum_q;
	logic                    wrap;

	assign sum_i = acc_i + i_in_i;
	assign sum_q = acc_q + i_in_q;
	assign wrap  = (cnt == SHIFT'(DECIM - 1));

	always_ff @(posedge ENC_CLK) begin
		if (i_rst) begin
			cnt     <= '0;
			acc_i   <= '0;
			acc_q   <= '0;
			o_valid <= 1'b0;
		end else begin
			cnt     <= cnt + 1'b1; // wraps at DECIM
			o_valid <= wrap;
			acc_i   <= wrap ? '0 : sum_i; // dump and restart
			acc_q   <= wrap ? '0 : sum_q;
		end
	end

	// top bits of the block sum, i.e. sum >>> SHIFT
	always_ff @(posedge ENC_CLK) begin
		if (wrap) begin
			o_out_i <= sum_i[AW-1:SHIFT];
			o_out_q <= sum_q[AW-1:SHIFT];
		end
	end

endmodule

//--- rtl/sample_source.sv
module sample_source #(
	parameter int CORDIC_STAGES = 14,
	parameter int DECIM         = 8
) (
	input  logic                                ENC_CLK,
	input  logic                                i_rst,
	input  logic signed [ddc_pkg::SAMPLE_W-1:0] i_adc_data,
	input  logic        [ddc_pkg::PHASE_W-1:0]  i_freq_word,
	input  ddc_pkg::capture_mode_t              i_mode,
	input  logic                                i_fifo_full,
	input  logic                                i_fifo_empty,
	output logic                                o_fifo_wr,
	output logic      [2*ddc_pkg::SAMPLE_W-1:0] o_fifo_wdata
);
	import ddc_pkg::*;

	logic signed [SAMPLE_W-1:0] adc_r;
	logic signed [SAMPLE_W-1:0] raw_dly [0:CORDIC_STAGES];
	logic signed [SAMPLE_W-1:0] mix_i;
	logic signed [SAMPLE_W-1:0] mix_q;
	logic signed [SAMPLE_W-1:0] dec_i;
	logic signed [SAMPLE_W-1:0] dec_q;
	logic                       dec_valid;
	logic signed [SAMPLE_W-1:0] sel_i;
	logic signed [SAMPLE_W-1:0] sel_q;
	logic                       sel_stb;
	logic                       capture;

	always_ff @(posedge ENC_CLK) begin
		adc_r      <= i_adc_data; // buffer the adc
		raw_dly[0] <= adc_r;
		for (int k = 1; k <= CORDIC_STAGES; k++)
			raw_dly[k] <= raw_dly[k-1]; // match the cordic latency
	end

	nco_mixer #(.CORDIC_STAGES(CORDIC_STAGES)) u_nco (
		.ENC_CLK     (ENC_CLK),
		.i_rst       (i_rst),
		.i_freq_word (i_freq_word),
		.i_sample    (adc_r),
		.o_i         (mix_i),
		.o_q         (mix_q)
	);

	decimator #(.DECIM(DECIM)) u_dec (
		.ENC_CLK (ENC_CLK),
		.i_rst   (i_rst),
		.i_in_i  (mix_i),
		.i_in_q  (mix_q),
		.o_out_i (dec_i),
		.o_out_q (dec_q),
		.o_valid (dec_valid)
	);

	always_comb begin
		case (i_mode)
			MODE_RAW: begin
				sel_i   = raw_dly[CORDIC_STAGES];
				sel_q   = '0;
				sel_stb = 1'b1;
			end
			MODE_MIXED: begin
				sel_i   = mix_i;
				sel_q   = mix_q;
				sel_stb = 1'b1;
			end
			default: begin // decimated, also code 3
				sel_i   = dec_i;
				sel_q   = dec_q;
				sel_stb = dec_valid;
			end
		endcase
	end

	// start on empty, stop on full
	always_ff @(posedge ENC_CLK) begin
		if (i_rst)
			capture <= 1'b0;
		else if (i_fifo_full)
			capture <= 1'b0;
		else if (i_fifo_empty)
			capture <= 1'b1;
	end

	assign o_fifo_wr    = capture & sel_stb;
	assign o_fifo_wdata = {sel_i, sel_q};

endmodule

//--- rtl/sample_fifo.sv
module sample_fifo #(
	parameter int FIFO_DEPTH = 16
) (
	input  logic                             ENC_CLK,
	input  logic                             i_rst,
	input  logic                             i_wr,
	input  logic [2*ddc_pkg::SAMPLE_W-1:0]   i_wdata,
	input  logic                             i_rd,
	output logic [2*ddc_pkg::SAMPLE_W-1:0]   o_rdata,
	output logic                             o_full,
	output logic                             o_empty
);
	import ddc_pkg::*;

	localparam int AW = $clog2(FIFO_DEPTH);

	logic [2*SAMPLE_W-1:0] mem [FIFO_DEPTH];
	logic [AW:0]           wr_ptr; // extra msb tells full from empty
	logic [AW:0]           rd_ptr;
	logic                  do_wr;
	logic                  do_rd;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = i_wr & ~o_full;  // write on full is dropped
	assign do_rd = i_rd & ~o_empty;

	always_ff @(posedge ENC_CLK) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= i_wdata;
	end

	always_ff @(posedge ENC_CLK) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// show-ahead, head word visible while not empty
	assign o_rdata = mem[rd_ptr[AW-1:0]];

endmodule

//--- rtl/usb_writer.sv
module usb_writer (
	input  logic                             ENC_CLK,
	input  logic                             i_rst,
	input  logic                             i_fifo_empty,
	input  logic [2*ddc_pkg::SAMPLE_W-1:0]   i_fifo_rdata,
	input  logic                             i_usb_full,
	output logic                             o_fifo_rd,
	output logic                             o_usb_wr,
	output logic [ddc_pkg::SAMPLE_W-1:0]     o_usb_data
);
	import ddc_pkg::*;

	writer_state_t       state;
	logic [SAMPLE_W-1:0] held_i; // i half of the pair in flight

	// usb full only looked at here, a started pair always finishes
	assign o_fifo_rd = (state == ST_IDLE) && !i_fifo_empty && !i_usb_full;

	always_ff @(posedge ENC_CLK) begin
		if (o_fifo_rd)
			held_i <= i_fifo_rdata[2*SAMPLE_W-1:SAMPLE_W];
	end

	always_ff @(posedge ENC_CLK) begin
		if (i_rst) begin
			state      <= ST_IDLE;
			o_usb_wr   <= 1'b0;
			o_usb_data <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (o_fifo_rd) begin
						o_usb_wr   <= 1'b1;
						o_usb_data <= i_fifo_rdata[SAMPLE_W-1:0]; // q goes first
						state      <= ST_Q;
					end
				end
				ST_Q: begin
					o_usb_data <= held_i;
					state      <= ST_I;
				end
				default: begin
					o_usb_wr <= 1'b0; // pair done
					state    <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

//--- rtl/ddc_top.sv
module ddc_top #(
	parameter int CORDIC_STAGES = 14, // at most 16
	parameter int DECIM         = 8,
	parameter int FIFO_DEPTH    = 16
) (
	input  logic                             ENC_CLK,
	input  logic                             i_rst,
	input  logic                             i_reg_wr,
	input  logic [ddc_pkg::REG_ADDR_W-1:0]   i_reg_addr,
	input  logic [ddc_pkg::PHASE_W-1:0]      i_reg_data,
	input  logic [ddc_pkg::SAMPLE_W-1:0]     i_adc_data,
	input  logic                             i_usb_full,
	output logic                             o_usb_wr,
	output logic [ddc_pkg::SAMPLE_W-1:0]     o_usb_data
);
	import ddc_pkg::*;

	logic [PHASE_W-1:0]    freq_word;
	capture_mode_t         option_mode;
	logic                  fifo_wr;
	logic [2*SAMPLE_W-1:0] fifo_wdata;
	logic                  fifo_rd;
	logic [2*SAMPLE_W-1:0] fifo_rdata;
	logic                  fifo_full;
	logic                  fifo_empty;

	ddc_regs u_regs (
		.i_rst       (i_rst),
		.ENC_CLK     (ENC_CLK),
		.i_reg_wr    (i_reg_wr),
		.i_reg_addr  (i_reg_addr),
		.i_reg_data  (i_reg_data),
		.o_freq_word (freq_word),
		.o_mode      (option_mode)
	);

	sample_source #(.CORDIC_STAGES(CORDIC_STAGES), .DECIM(DECIM)) u_src (
		.ENC_CLK      (ENC_CLK),
		.i_rst        (i_rst),
		.i_adc_data   (i_adc_data),
		.i_freq_word  (freq_word),
		.i_mode       (option_mode),
		.i_fifo_full  (fifo_full),
		.i_fifo_empty (fifo_empty),
		.o_fifo_wr    (fifo_wr),
		.o_fifo_wdata (fifo_wdata)
	);

	sample_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.ENC_CLK (ENC_CLK),
		.i_rst   (i_rst),
		.i_wr    (fifo_wr),
		.i_wdata (fifo_wdata),
		.i_rd    (fifo_rd),
		.o_rdata (fifo_rdata),
		.o_full  (fifo_full),
		.o_empty (fifo_empty)
	);

	usb_writer u_usb (
		.ENC_CLK      (ENC_CLK),
		.i_rst        (i_rst),
		.i_fifo_empty (fifo_empty),
		.i_fifo_rdata (fifo_rdata),
		.i_usb_full   (i_usb_full),
		.o_fifo_rd    (fifo_rd),
		.o_usb_wr     (o_usb_wr),
		.o_usb_data   (o_usb_data)
	);

endmodule

//--- test/ddc_model.svh
`ifndef DDC_MODEL_SVH
`define DDC_MODEL_SVH

// raw capture puts the sample on i and zero on q
function automatic logic [31:0] raw_pair(input logic [15:0] sample);
	return {sample, 16'h0000};
endfunction

// rotate (sample/2, 0) by the phase, integer steps with two guard bits
function automatic logic [31:0] cordic_mix(input logic [15:0] sample,
		input logic [15:0] phase, input int stages);
	int          x;
	int          y;
	int          xn;
	logic [15:0] z;
	x = int'($signed(sample)) * 2; // sample/2 in units of a quarter lsb
	y = 0;
	z = phase;
	if (z[15] != z[14]) begin
		x = -x; // half turn brings the angle into +-90
		z = z + 16'h8000;
	end
	for (int s = 0; s < stages; s++) begin
		if (z[15]) begin
			xn = x + (y >>> s);
			y  = y - (x >>> s);
			z  = z + ddc_pkg::CORDIC_ATAN[s];
		end else begin
			xn = x - (y >>> s);
			y  = y + (x >>> s);
			z  = z - ddc_pkg::CORDIC_ATAN[s];
		end
		x = xn;
	end
	return {16'(x >>> 2), 16'(y >>> 2)};
endfunction

// block sums divided by the ratio, rounding toward minus infinity
function automatic logic [31:0] scale_block(input int sum_i, input int sum_q, input int ratio);
	int shift;
	shift = 0;
	while ((1 << shift) < ratio)
		shift++;
	return {16'(sum_i >>> shift), 16'(sum_q >>> shift)};
endfunction

`endif

//--- test/tb_ddc_top.sv
module tb_ddc_top;
	timeunit 1ns;
	timeprecision 100ps;

	import ddc_pkg::*;

	`include "ddc_model.svh"

	localparam int CORDIC_STAGES = 14;
	localparam int DECIM         = 8;
	localparam int FIFO_DEPTH    = 16;

	// segment lengths in clock cycles
	localparam int RST_CYC  = 16;
	localparam int RAW_CYC  = 300;
	localparam int MIX_CYC  = 300;
	localparam int DEC_CYC  = 400;
	localparam int HOLD_CYC = 100;
	localparam int TAIL_CYC = 200;
	localparam int TIMEOUT  = RST_CYC + RAW_CYC + 2 * MIX_CYC + 2 * DEC_CYC + HOLD_CYC
		+ 2 * TAIL_CYC + 200;

	logic                  ENC_CLK;
	logic                  i_rst;
	logic                  i_reg_wr;
	logic [REG_ADDR_W-1:0] i_reg_addr;
	logic [PHASE_W-1:0]    i_reg_data;
	logic [SAMPLE_W-1:0]   i_adc_data;
	logic                  i_usb_full;
	logic                  o_usb_wr;
	logic [SAMPLE_W-1:0]   o_usb_data;

	integer                seed;
	logic [PHASE_W-1:0]    model_phase; // mirror of the nco accumulator
	logic [PHASE_W-1:0]    model_freq;
	logic [SAMPLE_W-1:0]   pend_sample;
	logic                  pend_wr;
	logic [REG_ADDR_W-1:0] pend_addr;
	logic [PHASE_W-1:0]    pend_data;
	logic [SAMPLE_W-1:0]   samp_q [$]; // samples not yet seen at the output
	logic [15:0]           ph_q [$];   // phase each sample is mixed with
	capture_mode_t         chk_mode;
	logic                  resync;
	int                    resync_miss;
	logic                  hold_off;
	logic                  have_q;
	logic [SAMPLE_W-1:0]   q_word;
	int                    pair_cnt;
	int                    seg_mark;
	int                    cycle_cnt;

	ddc_top #(
		.CORDIC_STAGES (CORDIC_STAGES),
		.DECIM         (DECIM),
		.FIFO_DEPTH    (FIFO_DEPTH)
	) u_dut (
		.ENC_CLK    (ENC_CLK),
		.i_rst      (i_rst),
		.i_reg_wr   (i_reg_wr),
		.i_reg_addr (i_reg_addr),
		.i_reg_data (i_reg_data),
		.i_adc_data (i_adc_data),
		.i_usb_full (i_usb_full),
		.o_usb_wr   (o_usb_wr),
		.o_usb_data (o_usb_data)
	);

	always #20 ENC_CLK = ~ENC_CLK;

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic drop_head(input int n);
		repeat (n) begin
			samp_q.delete(0);
			ph_q.delete(0);
		end
	endtask

	function automatic logic [31:0] expect_at(input int k);
		if (chk_mode == MODE_RAW)
			return raw_pair(samp_q[k]);
		return cordic_mix(samp_q[k], ph_q[k], CORDIC_STAGES);
	endfunction

	function automatic logic [31:0] block_at(input int j);
		int          si;
		int          sq;
		logic [31:0] m;
		si = 0;
		sq = 0;
		for (int k = j; k < j + DECIM; k++) begin
			m  = cordic_mix(samp_q[k], ph_q[k], CORDIC_STAGES);
			si += int'($signed(m[31:16]));
			sq += int'($signed(m[15:0]));
		end
		return scale_block(si, sq, DECIM);
	endfunction

	function automatic int find_match(input logic [31:0] act);
		for (int k = 0; k < samp_q.size(); k++)
			if (expect_at(k) == act)
				return k;
		return -1;
	endfunction

	function automatic int find_block(input logic [31:0] act);
		for (int j = 0; j + DECIM <= samp_q.size(); j++)
			if (block_at(j) == act)
				return j;
		return -1;
	endfunction

	// pairs still in flight from the previous mode
	task automatic note_miss();
		resync_miss++;
		assert (resync_miss <= FIFO_DEPTH + 8) else report_failure(
			"output never lined up with the new mode after the option register write");
	endtask

	// raw and mixed, samples may be skipped but never reordered
	task automatic check_stream(input logic [31:0] act);
		int k;
		k = find_match(act);
		if (resync) begin
			if (k < 0) begin
				note_miss();
				return;
			end
			resync = 1'b0;
		end
		assert (k >= 0) else report_failure($sformatf(
			"error: o_usb_data pair {i,q} = %h, expected %h or a later sample in input order",
			act, samp_q.size() > 0 ? expect_at(0) : 32'h0));
		drop_head(k + 1);
		pair_cnt++;
	endtask

	// decimated, one block after another once aligned
	task automatic check_decim(input logic [31:0] act);
		int j;
		if (resync) begin
			j = find_block(act);
			if (j < 0) begin
				note_miss();
				return;
			end
			drop_head(j);
			resync = 1'b0;
		end
		assert (samp_q.size() >= DECIM) else report_failure(
			"a decimated pair came out before its input block was sent");
		assert (block_at(0) == act) else report_failure($sformatf(
			"error: o_usb_data pair {i,q} = %h, expected %h", act, block_at(0)));
		drop_head(DECIM);
		pair_cnt++;
	endtask

	// outputs are registered, so look at them mid cycle
	always @(negedge ENC_CLK) begin
		if (i_rst) begin
			assert (o_usb_wr === 1'b0) else report_failure($sformatf(
				"error: o_usb_wr = %h in reset, expected 0", o_usb_wr));
			assert (o_usb_data === '0) else report_failure($sformatf(
				"error: o_usb_data = %h in reset, expected 0000", o_usb_data));
			have_q = 1'b0;
		end else if (o_usb_wr) begin
			assert (!hold_off) else report_failure(
				"o_usb_wr pulsed while i_usb_full was held high");
			if (!have_q) begin
				q_word = o_usb_data; // q comes first
				have_q = 1'b1;
			end else begin
				have_q = 1'b0;
				if (chk_mode == MODE_DECIM)
					check_decim({o_usb_data, q_word});
				else
					check_stream({o_usb_data, q_word});
			end
		end else begin
			assert (!have_q) else report_failure(
				"a q word was not followed by its i word on the next cycle");
		end
	end

	always @(posedge ENC_CLK) begin
		cycle_cnt++;
		if (cycle_cnt >= TIMEOUT)
			report_failure($sformatf("timeout, run still going after %0d cycles", cycle_cnt));
	end

	// one clock, model update on the edge, new inputs 2 ns later
	task automatic step();
		@(posedge ENC_CLK);
		if (i_rst) begin
			model_phase = '0;
			model_freq  = '0;
		end else begin
			model_phase = model_phase + model_freq; // old word, the write lands after
			if (pend_wr && pend_addr == ADDR_FREQ)
				model_freq = pend_data;
		end
		samp_q.push_back(pend_sample);
		ph_q.push_back(model_phase[PHASE_W-1 -: 16]);
		pend_wr = 1'b0;
		#2;
		pend_sample = 16'($random(seed));
		i_adc_data  = pend_sample;
		i_reg_wr    = 1'b0;
	endtask

	task automatic run(input int n);
		repeat (n) step();
	endtask

	task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [PHASE_W-1:0] data);
		step();
		i_reg_wr   = 1'b1;
		i_reg_addr = addr;
		i_reg_data = data;
		pend_wr    = 1'b1;
		pend_addr  = addr;
		pend_data  = data;
	endtask

	task automatic set_mode(input capture_mode_t m);
		reg_write(ADDR_OPTION, 32'(m));
		chk_mode    = m;
		resync      = 1'b1;
		resync_miss = 0;
	endtask

	task automatic end_segment(input string name);
		assert (pair_cnt > seg_mark) else report_failure($sformatf(
			"no pairs came out during the %s segment", name));
		seg_mark = pair_cnt;
	endtask

	initial begin
		ENC_CLK     = 1'b0;
		seed        = 32'hcdca_d975;
		i_rst       = 1'b1;
		i_reg_wr    = 1'b0;
		i_reg_addr  = '0;
		i_reg_data  = '0;
		i_usb_full  = 1'b0;
		model_phase = '0;
		model_freq  = '0;
		pend_wr     = 1'b0;
		pend_addr   = '0;
		pend_data   = '0;
		chk_mode    = MODE_RAW;
		resync      = 1'b0; // raw stream must line up from the first pair
		resync_miss = 0;
		hold_off    = 1'b0;
		have_q      = 1'b0;
		q_word      = '0;
		pair_cnt    = 0;
		seg_mark    = 0;
		cycle_cnt   = 0;
		pend_sample = 16'($random(seed));
		i_adc_data  = pend_sample;

		run(RST_CYC);
		i_rst = 1'b0;
		run(RAW_CYC);
		end_segment("raw");

		set_mode(MODE_MIXED);
		run(MIX_CYC);
		end_segment("mixed");

		set_mode(MODE_DECIM);
		run(DEC_CYC);
		end_segment("decimated");

		reg_write(ADDR_FREQ, 32'h0a3d_70a4);
		run(DEC_CYC);
		end_segment("tuned decimated");

		set_mode(MODE_MIXED);
		run(MIX_CYC);
		end_segment("tuned mixed");

		// usb side stalls, a pair already started may still finish
		step();
		i_usb_full = 1'b1;
		run(3);
		hold_off = 1'b1;
		run(HOLD_CYC - 3);
		hold_off   = 1'b0;
		i_usb_full = 1'b0;
		run(TAIL_CYC);
		end_segment("back-pressure");

		reg_write(7'h03, 32'h0000_0002); // neither address is mapped
		reg_write(7'h41, 32'h5555_5555);
		run(TAIL_CYC);
		end_segment("unmapped write");

		$display("test passed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+test
rtl/ddc_pkg.sv
rtl/ddc_regs.sv
rtl/nco_mixer.sv
rtl/decimator.sv
rtl/sample_source.sv
rtl/sample_fifo.sv
rtl/usb_writer.sv
rtl/ddc_top.sv
test/tb_ddc_top.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_ddc_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
